/* common/replay_pkg.sv */
//************************************************************
// Shared constants of the replay engine: bus widths, register
// map, field positions and reset defaults
// Register map is fixed, WO then RW then RO, one word each
//************************************************************
`default_nettype none

package replay_pkg;

   // Bus and stream widths
   localparam int data_width = 32;
   localparam int addr_width = 32;
   // Byte address to word address shift
   localparam int addr_lsb = $clog2(data_width / 8);

   // Register sections, in address order
   localparam int num_wo_regs = 3;
   localparam int num_rw_regs = 1;
   localparam int num_ro_regs = 3;
   localparam int num_regs = num_wo_regs + num_rw_regs + num_ro_regs;

   // Word indices
   localparam int reg_pkt_len = 0;
   localparam int reg_pkt_count = 1;
   localparam int reg_ipg = 2;
   localparam int reg_ctrl = 3;
   localparam int reg_status = 4;
   localparam int reg_pkts_sent = 5;
   localparam int reg_words_sent = 6;

   // Reset values of the writable registers
   localparam logic [data_width-1:0] def_pkt_len = 32'd4;
   localparam logic [data_width-1:0] def_pkt_count = 32'd1;
   localparam logic [data_width-1:0] def_ipg = 32'd0;
   localparam logic [data_width-1:0] def_ctrl = 32'd0;

   // Bit positions in ctrl and status
   localparam int ctrl_enable_bit = 0;
   localparam int status_busy_bit = 0;
   localparam int status_done_bit = 1;

   // Packet format
   localparam logic [7:0] hdr_tag = 8'hA5;
   // Low bits of pkt_len that count
   localparam int len_width = 8;
   // Sequence number field
   localparam int seq_width = 16;

endpackage

`default_nettype wire

/* ipif_regs/ipif_regs.sv */
//************************************************************
// Register file on the IPIF-style chip-select/ack bus
// One ack per access, one cycle after cs is sampled
// Byte enables are not honoured so only full-word writes work
// Bad section or out-of-map address gives error and zero data
//************************************************************
`default_nettype none

module ipif_regs (
   input  wire logic                              Bus2IP_Clk,
   input  wire logic                              rst,
   input  wire logic [replay_pkg::addr_width-1:0] bus2ip_addr,
   input  wire logic                              bus2ip_cs,
   input  wire logic                              bus2ip_rnw,
   input  wire logic [replay_pkg::data_width-1:0] bus2ip_data,
   input  wire logic [replay_pkg::data_width/8-1:0] bus2ip_be,
   output logic      [replay_pkg::data_width-1:0] ip2bus_data,
   output logic                                   ip2bus_rdack,
   output logic                                   ip2bus_wrack,
   output logic                                   ip2bus_error,
   output logic      [replay_pkg::data_width-1:0] pkt_len,
   output logic      [replay_pkg::data_width-1:0] pkt_count,
   output logic      [replay_pkg::data_width-1:0] ipg,
   output logic      [replay_pkg::data_width-1:0] ctrl,
   // Bit 0 busy, bit 1 done
   input  wire logic [1:0]                        status,
   input  wire logic [replay_pkg::data_width-1:0] pkts_sent,
   input  wire logic [replay_pkg::data_width-1:0] words_sent
);

   import replay_pkg::*;

   logic [addr_width-addr_lsb-1:0] word_idx;
   logic                           accept;
   logic                           in_map;
   logic                           rd_ok;
   logic                           wr_ok;
   logic [data_width-1:0]          rd_word;

   // Upper address bits kept so far addresses miss the map
   assign word_idx = bus2ip_addr[addr_width-1:addr_lsb];
   // Cs stays high through our own ack cycle
   assign accept = bus2ip_cs && !(ip2bus_rdack || ip2bus_wrack);

   // Section decode
   assign in_map = word_idx < num_regs;
   assign rd_ok = in_map && (word_idx >= num_wo_regs);
   assign wr_ok = word_idx < (num_wo_regs + num_rw_regs);

   // Read mux over RW and RO sections
   always_comb begin
      rd_word = '0;
      case (word_idx)
         reg_ctrl: rd_word = ctrl;
         reg_status: begin
            rd_word[status_busy_bit] = status[0];
            rd_word[status_done_bit] = status[1];
         end
         reg_pkts_sent: rd_word = pkts_sent;
         reg_words_sent: rd_word = words_sent;
         default: rd_word = '0;
      endcase
   end

   always_ff @(posedge Bus2IP_Clk) begin
      if (rst) begin
         pkt_len <= def_pkt_len;
         pkt_count <= def_pkt_count;
         ipg <= def_ipg;
         ctrl <= def_ctrl;
         ip2bus_data <= '0;
         ip2bus_rdack <= 1'b0;
         ip2bus_wrack <= 1'b0;
         ip2bus_error <= 1'b0;
      end else begin
         // Acks and error last one cycle
         ip2bus_rdack <= 1'b0;
         ip2bus_wrack <= 1'b0;
         ip2bus_error <= 1'b0;
         if (accept && bus2ip_rnw) begin
            ip2bus_rdack <= 1'b1;
            ip2bus_error <= !rd_ok;
            // Read mux gives zero outside the readable sections
            ip2bus_data <= rd_word;
         end
         if (accept && !bus2ip_rnw) begin
            ip2bus_wrack <= 1'b1;
            ip2bus_error <= !wr_ok;
            ip2bus_data <= '0;
            // Register file untouched on error
            if (wr_ok) begin
               case (word_idx)
                  reg_pkt_len: pkt_len <= bus2ip_data;
                  reg_pkt_count: pkt_count <= bus2ip_data;
                  reg_ipg: ipg <= bus2ip_data;
                  reg_ctrl: ctrl <= bus2ip_data;
                  default: ctrl <= ctrl;
               endcase
            end
         end
      end
   end

   // Never both acks at once
   a_one_ack: assert property (@(posedge Bus2IP_Clk) disable iff (rst)
      !(ip2bus_rdack && ip2bus_wrack));

   // One ack per access since the master drops cs after it
   a_ack_pulse: assert property (@(posedge Bus2IP_Clk) disable iff (rst)
      (ip2bus_rdack || ip2bus_wrack) |=> !(ip2bus_rdack || ip2bus_wrack));

   // Partial writes are outside what the master may issue
   a_full_word: assert property (@(posedge Bus2IP_Clk) disable iff (rst)
      (bus2ip_cs && !bus2ip_rnw) |-> (&bus2ip_be));

endmodule

`default_nettype wire

/* verilog/replay_sched.sv */
//************************************************************
// Packet scheduler, runs on a rising edge of enable
// Enable toggled before the run finishes is not seen
// Count of zero finishes at once with nothing sent
//************************************************************
`default_nettype none

module replay_sched (
   input  wire logic                              Bus2IP_Clk,
   input  wire logic                              rst,
   input  wire logic                              enable,
   input  wire logic [replay_pkg::data_width-1:0] pkt_count,
   input  wire logic [replay_pkg::data_width-1:0] ipg,
   input  wire logic                              pkt_done,
   output logic                                   start,
   output logic      [replay_pkg::seq_width-1:0]  seq,
   output logic                                   run_start,
   output logic                                   busy,
   output logic                                   done,
   output logic      [replay_pkg::data_width-1:0] pkts_sent
);

   import replay_pkg::*;

   typedef enum logic [1:0] {st_idle, st_issue, st_wait, st_gap} state_t;

   state_t                state;
   logic                  en_q;
   logic [data_width-1:0] gap_cnt;
   logic                  pkt_open;

   always_ff @(posedge Bus2IP_Clk) begin
      if (rst) begin
         state <= st_idle;
         en_q <= 1'b0;
         start <= 1'b0;
         run_start <= 1'b0;
         busy <= 1'b0;
         done <= 1'b0;
         pkts_sent <= '0;
         gap_cnt <= '0;
      end else begin
         en_q <= enable;
         start <= 1'b0;
         run_start <= 1'b0;
         case (state)
            st_idle: begin
               // New run on enable edge
               if (enable && !en_q) begin
                  run_start <= 1'b1;
                  pkts_sent <= '0;
                  done <= 1'b0;
                  busy <= 1'b1;
                  state <= st_issue;
               end
            end
            st_issue: begin
               // Zero count or enable dropped during gap
               if (pkts_sent >= pkt_count || !enable) begin
                  busy <= 1'b0;
                  done <= 1'b1;
                  state <= st_idle;
               end else begin
                  start <= 1'b1;
                  seq <= pkts_sent[seq_width-1:0];
                  state <= st_wait;
               end
            end
            st_wait: begin
               if (pkt_done) begin
                  pkts_sent <= pkts_sent + 1'b1;
                  // Last packet or stop request
                  if ((pkts_sent + 1'b1) >= pkt_count || !enable) begin
                     busy <= 1'b0;
                     done <= 1'b1;
                     state <= st_idle;
                  end else begin
                     gap_cnt <= ipg;
                     state <= st_gap;
                  end
               end
            end
            default: begin
               // Inter-packet gap count down
               if (gap_cnt == '0) begin
                  state <= st_issue;
               end else begin
                  gap_cnt <= gap_cnt - 1'b1;
               end
            end
         endcase
      end
   end

   // Packet in flight between start and pkt_done
   always_ff @(posedge Bus2IP_Clk) begin
      if (rst) begin
         pkt_open <= 1'b0;
      end else if (start) begin
         pkt_open <= 1'b1;
      end else if (pkt_done) begin
         pkt_open <= 1'b0;
      end
   end

   // Generator must be idle when start arrives
   a_no_overlap: assert property (@(posedge Bus2IP_Clk) disable iff (rst)
      start |-> !pkt_open);

endmodule

`default_nettype wire

/* verilog/replay_gen.sv */
//************************************************************
// Word generator, one packet per start pulse
// Only the low len_width bits of pkt_len count, 0 means 1
// Start must not arrive while a packet is being sent
//************************************************************
`default_nettype none

module replay_gen (
   input  wire logic                              Bus2IP_Clk,
   input  wire logic                              rst,
   input  wire logic                              start,
   input  wire logic [replay_pkg::seq_width-1:0]  seq,
   input  wire logic [replay_pkg::data_width-1:0] pkt_len,
   input  wire logic                              ready,
   output logic                                   valid,
   output logic      [replay_pkg::data_width-1:0] word,
   output logic                                   last,
   output logic                                   pkt_done
);

   import replay_pkg::*;

   logic [len_width-1:0] idx;
   logic [len_width-1:0] len_q;
   logic [len_width-1:0] eff_len;
   logic [seq_width-1:0] seq_q;

   // Zero length sends a bare header
   assign eff_len = (pkt_len[len_width-1:0] == '0) ? len_width'(1) : pkt_len[len_width-1:0];

   // Header first, then seq and word index
   assign word = (idx == '0) ? {hdr_tag, seq_q, len_q}
      : {seq_q, {(data_width - seq_width - len_width){1'b0}}, idx};
   assign last = (idx == len_q - 1'b1);

   always_ff @(posedge Bus2IP_Clk) begin
      if (rst) begin
         valid <= 1'b0;
         pkt_done <= 1'b0;
         idx <= '0;
      end else begin
         pkt_done <= 1'b0;
         if (start) begin
            valid <= 1'b1;
            idx <= '0;
         end else if (valid && ready) begin
            if (last) begin
               // Packet handed over in full
               valid <= 1'b0;
               pkt_done <= 1'b1;
            end else begin
               idx <= idx + 1'b1;
            end
         end
      end
   end

   // Packet fields, captured once per packet
   always_ff @(posedge Bus2IP_Clk) begin
      if (start) begin
         seq_q <= seq;
         len_q <= eff_len;
      end
   end

   // Stalled word stays put until taken
   a_hold: assert property (@(posedge Bus2IP_Clk) disable iff (rst)
      (valid && !ready) |=> (valid && $stable(word) && $stable(last)));

endmodule

`default_nettype wire

/* verilog/replay_tx.sv */
//************************************************************
// Output transmitter moving one word per four-phase req/ack cycle
// Sink must keep out_ack low until out_req is raised
//************************************************************
`default_nettype none

module replay_tx (
   input  wire logic                              Bus2IP_Clk,
   input  wire logic                              rst,
   input  wire logic                              run_start,
   input  wire logic                              valid,
   input  wire logic [replay_pkg::data_width-1:0] word,
   input  wire logic                              last,
   input  wire logic                              out_ack,
   output logic                                   ready,
   output logic                                   out_req,
   output logic      [replay_pkg::data_width-1:0] out_data,
   output logic                                   out_last,
   output logic      [replay_pkg::data_width-1:0] words_sent
);

   import replay_pkg::*;

   typedef enum logic [1:0] {st_idle, st_req, st_rel} state_t;

   state_t state;

   // Take a word only when the last exchange is fully closed
   assign ready = (state == st_idle);

   always_ff @(posedge Bus2IP_Clk) begin
      if (rst) begin
         state <= st_idle;
         out_req <= 1'b0;
      end else begin
         case (state)
            st_idle: begin
               if (valid) begin
                  out_req <= 1'b1;
                  state <= st_req;
               end
            end
            st_req: begin
               // Sink took the word
               if (out_ack) begin
                  out_req <= 1'b0;
                  state <= st_rel;
               end
            end
            default: begin
               // Wait for ack to drop
               if (!out_ack) begin
                  state <= st_idle;
               end
            end
         endcase
      end
   end

   // Completed exchanges in this run
   always_ff @(posedge Bus2IP_Clk) begin
      if (rst || run_start) begin
         words_sent <= '0;
      end else if (state == st_rel && !out_ack) begin
         words_sent <= words_sent + 1'b1;
      end
   end

   // Data and last held for the whole exchange
   always_ff @(posedge Bus2IP_Clk) begin
      if (ready && valid) begin
         out_data <= word;
         out_last <= last;
      end
   end

   // Req only rises from a cycle in which ack was low
   a_req_rise: assert property (@(posedge Bus2IP_Clk) disable iff (rst)
      $rose(out_req) |-> !$past(out_ack));

endmodule

`default_nettype wire

/* verilog/pcap_replay_top.sv */
//************************************************************
// Replay engine top: registers, scheduler, generator and
// transmitter in a chain, bus in and four-phase port out
//************************************************************
`default_nettype none

module pcap_replay_top (
   input  wire logic                                Bus2IP_Clk,
   input  wire logic                                rst,
   input  wire logic [replay_pkg::addr_width-1:0]   bus2ip_addr,
   input  wire logic                                bus2ip_cs,
   input  wire logic                                bus2ip_rnw,
   input  wire logic [replay_pkg::data_width-1:0]   bus2ip_data,
   input  wire logic [replay_pkg::data_width/8-1:0] bus2ip_be,
   output logic      [replay_pkg::data_width-1:0]   ip2bus_data,
   output logic                                     ip2bus_rdack,
   output logic                                     ip2bus_wrack,
   output logic                                     ip2bus_error,
   output logic                                     out_req,
   output logic      [replay_pkg::data_width-1:0]   out_data,
   output logic                                     out_last,
   input  wire logic                                out_ack
);

   import replay_pkg::*;

   // Register values
   logic [data_width-1:0] pkt_len;
   logic [data_width-1:0] pkt_count;
   logic [data_width-1:0] ipg;
   logic [data_width-1:0] ctrl;
   // Progress back to registers
   logic                  busy;
   logic                  done;
   logic [data_width-1:0] pkts_sent;
   logic [data_width-1:0] words_sent;
   // Scheduler to generator
   logic                  start;
   logic [seq_width-1:0]  seq;
   logic                  run_start;
   logic                  pkt_done;
   // Word stream
   logic                  valid;
   logic                  ready;
   logic [data_width-1:0] word;
   logic                  last;

   ipif_regs ipif_regs_inst (
      .Bus2IP_Clk   (Bus2IP_Clk),
      .rst          (rst),
      .bus2ip_addr  (bus2ip_addr),
      .bus2ip_cs    (bus2ip_cs),
      .bus2ip_rnw   (bus2ip_rnw),
      .bus2ip_data  (bus2ip_data),
      .bus2ip_be    (bus2ip_be),
      .ip2bus_data  (ip2bus_data),
      .ip2bus_rdack (ip2bus_rdack),
      .ip2bus_wrack (ip2bus_wrack),
      .ip2bus_error (ip2bus_error),
      .pkt_len      (pkt_len),
      .pkt_count    (pkt_count),
      .ipg          (ipg),
      .ctrl         (ctrl),
      .status       ({done, busy}),
      .pkts_sent    (pkts_sent),
      .words_sent   (words_sent)
   );

   replay_sched replay_sched_inst (
      .Bus2IP_Clk (Bus2IP_Clk),
      .rst        (rst),
      .enable     (ctrl[ctrl_enable_bit]),
      .pkt_count  (pkt_count),
      .ipg        (ipg),
      .pkt_done   (pkt_done),
      .start      (start),
      .seq        (seq),
      .run_start  (run_start),
      .busy       (busy),
      .done       (done),
      .pkts_sent  (pkts_sent)
   );

   replay_gen replay_gen_inst (
      .Bus2IP_Clk (Bus2IP_Clk),
      .rst        (rst),
      .start      (start),
      .seq        (seq),
      .pkt_len    (pkt_len),
      .ready      (ready),
      .valid      (valid),
      .word       (word),
      .last       (last),
      .pkt_done   (pkt_done)
   );

   replay_tx replay_tx_inst (
      .Bus2IP_Clk (Bus2IP_Clk),
      .rst        (rst),
      .run_start  (run_start),
      .valid      (valid),
      .word       (word),
      .last       (last),
      .out_ack    (out_ack),
      .ready      (ready),
      .out_req    (out_req),
      .out_data   (out_data),
      .out_last   (out_last),
      .words_sent (words_sent)
   );

endmodule

`default_nettype wire

/* bench/replay_tb.sv */
//************************************************************
// Directed testbench for the packet replay engine
// Bus and sink are driven on the falling clock edge
// Sink ack delays come from a 16-bit LFSR with seed 15697
// Stops at the first failed check
//************************************************************
`default_nettype none

module replay_tb;

   timeunit 1ns;
   timeprecision 1ps;

   import replay_pkg::*;

   localparam int clk_period = 100;
   // Longest wait for an ack or a request, in cycles
   localparam int wait_max = 64;
   // Status polls before a run counts as stuck
   localparam int poll_max = 200;
   // Worst case over all tests in words, cycles per word and bus traffic
   localparam int max_words = 80;
   localparam int cycles_per_word = 20;
   localparam int bus_cycles = 1500;
   localparam int watchdog_ns = (max_words * cycles_per_word + bus_cycles) * clk_period;

   logic                    Bus2IP_Clk;
   logic                    rst;
   logic [addr_width-1:0]   bus2ip_addr;
   logic                    bus2ip_cs;
   logic                    bus2ip_rnw;
   logic [data_width-1:0]   bus2ip_data;
   logic [data_width/8-1:0] bus2ip_be;
   logic [data_width-1:0]   ip2bus_data;
   logic                    ip2bus_rdack;
   logic                    ip2bus_wrack;
   logic                    ip2bus_error;
   logic                    out_req;
   logic [data_width-1:0]   out_data;
   logic                    out_last;
   logic                    out_ack;

   logic [15:0] lfsr_state = 16'd15697;
   int          req_rises = 0;

   pcap_replay_top pcap_replay_top_inst (
      .Bus2IP_Clk   (Bus2IP_Clk),
      .rst          (rst),
      .bus2ip_addr  (bus2ip_addr),
      .bus2ip_cs    (bus2ip_cs),
      .bus2ip_rnw   (bus2ip_rnw),
      .bus2ip_data  (bus2ip_data),
      .bus2ip_be    (bus2ip_be),
      .ip2bus_data  (ip2bus_data),
      .ip2bus_rdack (ip2bus_rdack),
      .ip2bus_wrack (ip2bus_wrack),
      .ip2bus_error (ip2bus_error),
      .out_req      (out_req),
      .out_data     (out_data),
      .out_last     (out_last),
      .out_ack      (out_ack)
   );

   initial begin
      Bus2IP_Clk = 1'b0;
      forever #(clk_period / 2) Bus2IP_Clk = ~Bus2IP_Clk;
   end

   // Counts every request on the output port
   always @(posedge out_req) req_rises <= req_rises + 1;

   initial begin
      #(watchdog_ns);
      $display("Watchdog expired before the tests finished");
      $display("ERRORS FOUND");
      $fatal(1, "run stopped by watchdog");
   end

   task check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
      assert (got === exp) else begin
         $display("CHECK FAILED: %s got %h expected %h", name, got, exp);
         $display("ERRORS FOUND");
         $fatal(1, "stopping on first error");
      end
   endtask

   task report_hang(input string what);
      $display("%s", what);
      $display("ERRORS FOUND");
      $fatal(1, "stopping on a stuck handshake");
   endtask

   // Taps 16, 14, 13, 11
   function logic [15:0] lfsr_next(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   // One LFSR step per bit taken
   task take_bits(input int n, output logic [7:0] val);
      val = '0;
      for (int k = 0; k < n; k++) begin
         lfsr_state = lfsr_next(lfsr_state);
         val = {val[6:0], lfsr_state[0]};
      end
   endtask

   // Header carries tag, seq and length
   // Payload carries seq, a zero byte and the index
   function logic [31:0] expected_word(input logic [15:0] sq, input logic [7:0] len,
                                       input logic [7:0] idx);
      if (idx == 8'd0)
         return {8'hA5, sq, len};
      return {sq, 8'h00, idx};
   endfunction

   task bus_access(input logic rnw, input int idx, input logic [31:0] wdata,
                   output logic [31:0] rdata, output logic err);
      int cnt;
      cnt = 0;
      bus2ip_addr = 32'(idx) << 2;
      bus2ip_rnw = rnw;
      bus2ip_data = wdata;
      bus2ip_cs = 1'b1;
      do begin
         @(negedge Bus2IP_Clk);
         cnt++;
         if (cnt > wait_max)
            report_hang("Bus access got no ack");
      end while (!(ip2bus_rdack || ip2bus_wrack));
      check_eq("ip2bus_rdack", 32'(ip2bus_rdack), 32'(rnw));
      check_eq("ip2bus_wrack", 32'(ip2bus_wrack), 32'(!rnw));
      rdata = ip2bus_data;
      err = ip2bus_error;
      // Cs low for one cycle between accesses
      bus2ip_cs = 1'b0;
      bus2ip_rnw = 1'b1;
      @(negedge Bus2IP_Clk);
   endtask

   task bus_write(input int idx, input logic [31:0] data, output logic err);
      logic [31:0] unused_data;
      bus_access(1'b0, idx, data, unused_data, err);
   endtask

   task bus_read(input int idx, output logic [31:0] data, output logic err);
      bus_access(1'b1, idx, '0, data, err);
   endtask

   task write_ok(input int idx, input logic [31:0] data);
      logic err;
      bus_write(idx, data, err);
      check_eq("ip2bus_error on write", 32'(err), 32'd0);
   endtask

   task read_expect(input int idx, input logic [31:0] exp, input string name);
      logic [31:0] data;
      logic        err;
      bus_read(idx, data, err);
      check_eq("ip2bus_error on read", 32'(err), 32'd0);
      check_eq(name, data, exp);
   endtask

   // Output sink for one packet with a random ack delay per word
   task sink_packet(input int seq_no, input int len);
      int         cnt;
      logic [7:0] dly;
      for (int i = 0; i < len; i++) begin
         cnt = 0;
         while (!out_req) begin
            @(negedge Bus2IP_Clk);
            cnt++;
            if (cnt > wait_max)
               report_hang("Transmitter raised no request for the next word");
         end
         check_eq("out_data", out_data, expected_word(16'(seq_no), 8'(len), 8'(i)));
         check_eq("out_last", 32'(out_last), 32'(i == len - 1));
         take_bits(2, dly);
         repeat (dly) @(negedge Bus2IP_Clk);
         out_ack = 1'b1;
         cnt = 0;
         do begin
            @(negedge Bus2IP_Clk);
            cnt++;
            if (cnt > wait_max)
               report_hang("Transmitter kept its request up after the ack");
         end while (out_req);
         out_ack = 1'b0;
      end
   endtask

   // New run needs a rising edge of enable
   task start_run(input int len, input int count, input int gap);
      write_ok(reg_pkt_len, 32'(len));
      write_ok(reg_pkt_count, 32'(count));
      write_ok(reg_ipg, 32'(gap));
      write_ok(reg_ctrl, 32'd0);
      write_ok(reg_ctrl, 32'd1);
   endtask

   task wait_done;
      logic [31:0] data;
      logic        err;
      int          polls;
      polls = 0;
      do begin
         bus_read(reg_status, data, err);
         polls++;
         if (polls > poll_max)
            report_hang("Run never reported done");
      end while (!data[1]);
   endtask

   task check_run_end(input int exp_pkts, input int exp_words);
      wait_done();
      read_expect(reg_pkts_sent, 32'(exp_pkts), "reg_pkts_sent");
      read_expect(reg_words_sent, 32'(exp_words), "reg_words_sent");
      // Done set and busy clear
      read_expect(reg_status, 32'd2, "reg_status");
   endtask

   task test_reset_decode;
      logic [31:0] data;
      logic        err;
      read_expect(reg_ctrl, 32'd0, "reg_ctrl");
      read_expect(reg_status, 32'd0, "reg_status");
      read_expect(reg_pkts_sent, 32'd0, "reg_pkts_sent");
      // Write-only section is not readable
      bus_read(reg_pkt_len, data, err);
      check_eq("ip2bus_error reading reg_pkt_len", 32'(err), 32'd1);
      check_eq("ip2bus_data on error", data, 32'd0);
      bus_write(reg_status, 32'h3, err);
      check_eq("ip2bus_error writing reg_status", 32'(err), 32'd1);
      read_expect(reg_status, 32'd0, "reg_status after bad write");
      // Beyond the map
      bus_read(7, data, err);
      check_eq("ip2bus_error reading past map", 32'(err), 32'd1);
      check_eq("ip2bus_data past map", data, 32'd0);
      bus_write(40, 32'h1234, err);
      check_eq("ip2bus_error writing past map", 32'(err), 32'd1);
   endtask

   task test_writable_regs;
      write_ok(reg_ctrl, 32'h5A5A_0000);
      read_expect(reg_ctrl, 32'h5A5A_0000, "reg_ctrl");
      write_ok(reg_ctrl, 32'd0);
      // Header length byte checked by the sink
      start_run(6, 1, 0);
      sink_packet(0, 6);
      check_run_end(1, 6);
   endtask

   task test_full_run;
      start_run(5, 3, 2);
      for (int p = 0; p < 3; p++)
         sink_packet(p, 5);
      check_run_end(3, 15);
   endtask

   task test_back_pressure;
      logic [7:0] bits;
      int         len;
      for (int r = 0; r < 2; r++) begin
         take_bits(3, bits);
         len = int'(bits) + 1;
         start_run(len, 3, 1);
         for (int p = 0; p < 3; p++)
            sink_packet(p, len);
         check_run_end(3, 3 * len);
      end
      // Length 0 gives bare headers of length 1
      start_run(0, 2, 0);
      sink_packet(0, 1);
      sink_packet(1, 1);
      check_run_end(2, 2);
   endtask

   task test_stop;
      logic [31:0] pkts;
      logic [31:0] words;
      logic        err;
      int          rises;
      // Long gap so the stop lands inside the first packet
      start_run(3, 10, 40);
      fork
         sink_packet(0, 3);
         begin
            while (!out_req)
               @(negedge Bus2IP_Clk);
            bus_write(reg_ctrl, 32'd0, err);
            check_eq("ip2bus_error clearing enable", 32'(err), 32'd0);
         end
      join
      wait_done();
      rises = req_rises;
      repeat (60) @(negedge Bus2IP_Clk);
      check_eq("requests after stop", 32'(req_rises), 32'(rises));
      bus_read(reg_pkts_sent, pkts, err);
      check_eq("ip2bus_error reading reg_pkts_sent", 32'(err), 32'd0);
      bus_read(reg_words_sent, words, err);
      check_eq("ip2bus_error reading reg_words_sent", 32'(err), 32'd0);
      check_eq("reg_pkts_sent below count", 32'(pkts < 32'd10), 32'd1);
      check_eq("reg_words_sent", words, pkts * 32'd3);
      read_expect(reg_status, 32'd2, "reg_status");
   endtask

   task test_zero_count;
      int rises;
      rises = req_rises;
      start_run(4, 0, 0);
      check_run_end(0, 0);
      repeat (20) @(negedge Bus2IP_Clk);
      check_eq("requests with zero count", 32'(req_rises), 32'(rises));
   endtask

   initial begin
      rst = 1'b1;
      bus2ip_addr = '0;
      bus2ip_cs = 1'b0;
      bus2ip_rnw = 1'b1;
      bus2ip_data = '0;
      bus2ip_be = '1;
      out_ack = 1'b0;
      repeat (3) @(posedge Bus2IP_Clk);
      @(negedge Bus2IP_Clk);
      rst = 1'b0;
      @(negedge Bus2IP_Clk);
      test_reset_decode();
      test_writable_regs();
      test_full_run();
      test_back_pressure();
      test_stop();
      test_zero_count();
      $display("NO ERRORS");
      $finish;
   end

endmodule

`default_nettype wire

/* pcap_replay.f */
common/replay_pkg.sv
ipif_regs/ipif_regs.sv
verilog/replay_sched.sv
verilog/replay_gen.sv
verilog/replay_tx.sv
verilog/pcap_replay_top.sv
bench/replay_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the replay engine testbench with Verilator.
# Exits 0 only when the simulation prints the pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module replay_tb \
   -f pcap_replay.f -o replay_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

sim_out=$(./obj_dir/replay_sim 2>&1)
sim_status=$?
echo "$sim_out"

if [ $sim_status -ne 0 ]; then
   echo "Simulation exited with status $sim_status"
   exit 1
fi

if echo "$sim_out" | grep -qx "NO ERRORS"; then
   echo "Simulation passed"
   exit 0
else
   echo "Simulation failed"
   exit 1
fi
